// ==== tb.f ====
+incdir+include
hw/cpu_types_pkg.sv
hw/board_types_pkg.sv
hw/reset_gen.sv
hw/test_rom.sv
hw/self_test_cpu.sv
hw/hex_digit.sv
hw/test_monitor.sv
hw/eco32_top.sv
sim/tb_eco32.sv

// ==== sim/tb_eco32.sv ====
// --------------------------------------------------------------------------
// ECO32 board self-test testbench: reset behavior, clean and faulted
// runs, verdict clearing and the key and switch indicator LEDs
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "eco32_defs.svh"

module tb_eco32
  import board_types_pkg::*;
();

  localparam int clk_period = 100;
  // reset plus hold, one fetch/execute/report per step and the end entry
  localparam int run_cycles = 5 + 3 * (`ECO32_STEPS + 1) + `ECO32_RST_HOLD + 3;
  localparam int n_runs     = 6;   // board runs over all tests

  logic        clk;
  logic        rst;
  logic        key3_n;
  logic        key2_n;
  logic        key1_n;
  logic [17:0] sw;
  logic [8:0]  led_g;
  logic [17:0] led_r;
  seg7_t       hex7_n;

  eco32_top uut (
    .clk    (clk),
    .rst    (rst),
    .key3_n (key3_n),
    .key2_n (key2_n),
    .key1_n (key1_n),
    .sw     (sw),
    .led_g  (led_g),
    .led_r  (led_r),
    .hex7_n (hex7_n)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(6 * run_cycles * n_runs * clk_period);
    $display("watchdog: the tests did not finish in the allowed time");
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  // --------------------------------------------------------------------------
  // reference data and helpers
  // --------------------------------------------------------------------------
  // active-low patterns, gfedcba
  function automatic seg7_t ref_seg(input logic [3:0] digit);
    case (digit)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h18;
      4'ha: return 7'h08;
      4'hb: return 7'h03;
      4'hc: return 7'h46;
      4'hd: return 7'h21;
      4'he: return 7'h06;
      default: return 7'h0e;
    endcase
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic verdict_t led_verdict();
    case ({led_g[7], led_r[0]})
      2'b00:   return v_running;
      2'b10:   return v_passed;
      2'b01:   return v_failed;
      default: return verdict_t'(2'b11);   // both on or unknown
    endcase
  endfunction

  task automatic cmp_seg(input string test, input logic [3:0] digit, input seg7_t act);
    if (act !== ref_seg(digit)) begin
      $display("mismatch %s: digit %0d expected %h actual %h", test, digit,
               ref_seg(digit), act);
      $display("*** FAILED ***");
      $fatal(1, "seven-segment check failed");
    end
  endtask

  task automatic cmp_verdict(input string test, input verdict_t exp, input verdict_t act);
    if (act !== exp) begin
      $display("mismatch %s: verdict expected %s actual %s (%b)", test, exp.name(),
               act.name(), act);
      $display("*** FAILED ***");
      $fatal(1, "verdict check failed");
    end
  endtask

  task automatic cmp_bit(input string test, input string what, input logic exp,
                         input logic act);
    if (act !== exp) begin
      $display("mismatch %s: %s expected %b actual %b", test, what, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "LED check failed");
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (5) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic wait_verdict(input string test);
    int n;
    n = 0;
    while (led_g[7] !== 1'b1 && led_r[0] !== 1'b1 && n < 2 * run_cycles) begin
      @(negedge clk);
      n++;
    end
    if (led_g[7] !== 1'b1 && led_r[0] !== 1'b1) begin
      $display("%s: no pass or fail LED came on after the self-test run", test);
      $display("*** FAILED ***");
      $fatal(1, "verdict never appeared");
    end
  endtask

  // one full board run with the given fault step on sw[3:0]
  task automatic do_run(input string test, input logic [3:0] fault);
    @(negedge clk);
    sw = {sw[17:4], fault};
    apply_reset();
    wait_verdict(test);
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------
  task automatic reset_state();
    @(negedge clk);
    rst = 1'b1;
    repeat (5) @(negedge clk);
    cmp_bit("reset_state", "led_g[2] in reset", 1'b1, led_g[2]);
    cmp_bit("reset_state", "led_g[1] heartbeat", 1'b0, led_g[1]);
    cmp_verdict("reset_state", v_running, led_verdict());
    cmp_seg("reset_state", 4'd0, hex7_n);
    rst = 1'b0;
    repeat (`ECO32_RST_HOLD) @(negedge clk);
    cmp_bit("reset_state", "led_g[2] during hold", 1'b1, led_g[2]);
    @(negedge clk);
    cmp_bit("reset_state", "led_g[2] after hold", 1'b0, led_g[2]);
    cmp_verdict("reset_state", v_running, led_verdict());
    cmp_seg("reset_state", 4'd0, hex7_n);
  endtask

  task automatic clean_run();
    do_run("clean_run", 4'd0);
    cmp_verdict("clean_run", v_passed, led_verdict());
    cmp_seg("clean_run", 4'(`ECO32_STEPS), hex7_n);
  endtask

  task automatic fault_runs();
    logic [31:0] rng;
    logic [3:0]  faults [3];
    rng = xorshift32(32'h86e8);
    faults[0] = 4'd1;
    faults[1] = 4'(`ECO32_STEPS);
    faults[2] = 4'((rng % `ECO32_STEPS) + 1);   // random step in 1..steps
    foreach (faults[i]) begin
      do_run("fault_runs", faults[i]);
      cmp_verdict("fault_runs", v_failed, led_verdict());
      cmp_seg("fault_runs", faults[i] - 4'd1, hex7_n);
    end
  endtask

  task automatic rerun_clears();
    do_run("rerun_clears", 4'd3);
    cmp_verdict("rerun_clears", v_failed, led_verdict());
    do_run("rerun_clears", 4'd0);
    cmp_verdict("rerun_clears", v_passed, led_verdict());
    cmp_seg("rerun_clears", 4'(`ECO32_STEPS), hex7_n);
  endtask

  task automatic board_indicators();
    @(negedge clk);
    sw = 18'h0;
    @(negedge clk);
    cmp_bit("board_indicators", "led_r[17] no switch", 1'b0, led_r[17]);
    sw = 18'h00010;   // lowest switch above the fault select
    @(negedge clk);
    cmp_bit("board_indicators", "led_r[17] sw[4]", 1'b1, led_r[17]);
    sw = 18'h20000;
    @(negedge clk);
    cmp_bit("board_indicators", "led_r[17] sw[17]", 1'b1, led_r[17]);
    cmp_bit("board_indicators", "unused LEDs", 1'b0,
            |{led_g[6:3], led_g[0], led_r[16:1]});
    sw = 18'h0;
    key3_n = 1'b0;
    key2_n = 1'b0;
    @(negedge clk);
    cmp_bit("board_indicators", "led_g[8] two keys", 1'b0, led_g[8]);
    key1_n = 1'b0;
    @(negedge clk);
    cmp_bit("board_indicators", "led_g[8] all keys", 1'b1, led_g[8]);
    key3_n = 1'b1;
    key2_n = 1'b1;
    key1_n = 1'b1;
    @(negedge clk);
    cmp_bit("board_indicators", "led_g[8] no key", 1'b0, led_g[8]);
  endtask

  initial begin
    rst    = 1'b1;
    key3_n = 1'b1;
    key2_n = 1'b1;
    key1_n = 1'b1;
    sw     = 18'h0;
    reset_state();
    clean_run();
    fault_runs();
    rerun_clears();
    board_indicators();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== hw/eco32_top.sv ====
// --------------------------------------------------------------------------
// ECO32 board top: reset generator, self-test CPU and test monitor
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module eco32_top
  import board_types_pkg::*;
(
  input  logic        clk,
  input  logic        rst,      // board reset, asynchronous
  input  logic        key3_n,
  input  logic        key2_n,
  input  logic        key1_n,
  input  logic [17:0] sw,
  output logic [8:0]  led_g,
  output logic [17:0] led_r,
  output seg7_t       hex7_n
);

  logic sys_rst;
  logic test_step;
  logic test_good;
  logic test_ended;

  reset_gen u_reset_gen (
    .clk     (clk),
    .rst     (rst),
    .sys_rst (sys_rst)
  );

  self_test_cpu u_cpu (
    .clk        (clk),
    .rst        (sys_rst),
    .fault_step (sw[3:0]),    // fault injection select
    .test_step  (test_step),
    .test_good  (test_good),
    .test_ended (test_ended)
  );

  test_monitor u_monitor (
    .clk        (clk),
    .rst        (sys_rst),
    .test_step  (test_step),
    .test_good  (test_good),
    .test_ended (test_ended),
    .key3_n     (key3_n),
    .key2_n     (key2_n),
    .key1_n     (key1_n),
    .sw         (sw),
    .led_g      (led_g),
    .led_r      (led_r),
    .hex7_n     (hex7_n)
  );

endmodule

// ==== hw/test_monitor.sv ====
// --------------------------------------------------------------------------
// test monitor: latches the verdict, counts good steps up to the first
// failure and drives the status LEDs and the count digit
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "eco32_defs.svh"

module test_monitor
  import board_types_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        test_step,
  input  logic        test_good,
  input  logic        test_ended,
  input  logic        key3_n,
  input  logic        key2_n,
  input  logic        key1_n,
  input  logic [17:0] sw,
  output logic [8:0]  led_g,
  output logic [17:0] led_r,
  output seg7_t       hex7_n
);

  verdict_t                  verdict;
  logic                      end_seen;
  logic [3:0]                good_cnt;   // good steps before first failure
  logic [`ECO32_HB_BITS-1:0] heartbeat;
  logic                      passed;
  logic                      failed;
  logic                      all_keys;

  always_ff @(posedge clk) begin
    if (rst) begin
      verdict  <= v_running;
      end_seen <= 1'b0;
      good_cnt <= 4'd0;
    end else if (!end_seen) begin   // late strobes ignored
      if (test_step) begin
        if (!test_good) begin
          verdict <= v_failed;
        end else if (verdict == v_running) begin
          good_cnt <= good_cnt + 4'd1;
        end
      end
      if (test_ended) begin
        end_seen <= 1'b1;
        if (verdict == v_running) begin
          verdict <= v_passed;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      heartbeat <= '0;
    end else begin
      heartbeat <= heartbeat + 1'b1;
    end
  end

  hex_digit u_digit (
    .value (good_cnt),
    .seg   (hex7_n)
  );

  // --------------------------------------------------------------------------
  // LEDs
  // --------------------------------------------------------------------------
  assign passed   = (verdict == v_passed);
  assign failed   = (verdict == v_failed);
  assign all_keys = ~key3_n & ~key2_n & ~key1_n;

  assign led_g = {all_keys, passed, 4'b0000, rst, heartbeat[`ECO32_HB_BITS-1], 1'b0};
  assign led_r = {|sw, 16'h0000, failed};

endmodule

// ==== hw/hex_digit.sv ====
// --------------------------------------------------------------------------
// hex digit decoder, active-low seven-segment output
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module hex_digit
  import board_types_pkg::*;
(
  input  logic [3:0] value,
  output seg7_t      seg
);

  always_comb begin
    case (value)
                  //  6543210
      4'h0: seg = ~7'b0111111;
      4'h1: seg = ~7'b0000110;
      4'h2: seg = ~7'b1011011;
      4'h3: seg = ~7'b1001111;
      4'h4: seg = ~7'b1100110;
      4'h5: seg = ~7'b1101101;
      4'h6: seg = ~7'b1111101;
      4'h7: seg = ~7'b0000111;
      4'h8: seg = ~7'b1111111;
      4'h9: seg = ~7'b1100111;
      4'ha: seg = ~7'b1110111;   // A
      4'hb: seg = ~7'b1111100;   // b
      4'hc: seg = ~7'b0111001;   // C
      4'hd: seg = ~7'b1011110;   // d
      4'he: seg = ~7'b1111001;   // E
      default: seg = ~7'b1110001;   // F
    endcase
  end

endmodule

// ==== hw/self_test_cpu.sv ====
// --------------------------------------------------------------------------
// self-test CPU: runs the ROM test program, one ALU check per step,
// and reports each step and the end of the program as strobes
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "eco32_defs.svh"

module self_test_cpu
  import cpu_types_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic [3:0] fault_step,   // step to corrupt, 0 = none
  output logic       test_step,
  output logic       test_good,
  output logic       test_ended
);

  cpu_state_t           state;
  logic [`ECO32_AW-1:0] pc;

  test_op_t             rom_op;
  logic [`ECO32_DW-1:0] rom_a;
  logic [`ECO32_DW-1:0] rom_b;
  logic [`ECO32_DW-1:0] rom_exp;

  test_op_t             ir_op;     // latched entry
  logic [`ECO32_DW-1:0] ir_a;
  logic [`ECO32_DW-1:0] ir_b;
  logic [`ECO32_DW-1:0] ir_exp;

  logic [`ECO32_DW-1:0] alu_out;
  logic [`ECO32_DW-1:0] result;
  logic                 fault_hit;

  test_rom u_rom (
    .addr     (pc),
    .op       (rom_op),
    .opa      (rom_a),
    .opb      (rom_b),
    .expected (rom_exp)
  );

  // --------------------------------------------------------------------------
  // ALU
  // --------------------------------------------------------------------------
  always_comb begin
    case (ir_op)
      op_add:  alu_out = ir_a + ir_b;
      op_sub:  alu_out = ir_a - ir_b;
      op_and:  alu_out = ir_a & ir_b;
      op_or:   alu_out = ir_a | ir_b;
      op_xor:  alu_out = ir_a ^ ir_b;
      op_shl:  alu_out = ir_a << ir_b[4:0];
      op_shr:  alu_out = ir_a >> ir_b[4:0];
      default: alu_out = '0;
    endcase
  end

  assign fault_hit = (fault_step == (pc + 4'd1));   // steps count from 1

  // --------------------------------------------------------------------------
  // control
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_fetch;
      pc    <= '0;
    end else begin
      case (state)
        st_fetch:  state <= st_exec;
        st_exec:   state <= st_report;
        st_report: begin
          if (ir_op == op_end) begin
            state <= st_halt;
          end else begin
            state <= st_fetch;
            pc    <= pc + 1'b1;
          end
        end
        default:   state <= st_halt;   // stays until reset
      endcase
    end
  end

  // entry latch and ALU result register
  always_ff @(posedge clk) begin
    if (state == st_fetch) begin
      ir_op  <= rom_op;
      ir_a   <= rom_a;
      ir_b   <= rom_b;
      ir_exp <= rom_exp;
    end
    if (state == st_exec) begin
      result <= alu_out ^ {{(`ECO32_DW-1){1'b0}}, fault_hit};
    end
  end

  assign test_step  = (state == st_report) && (ir_op != op_end);
  assign test_good  = test_step && (result == ir_exp);
  assign test_ended = (state == st_report) && (ir_op == op_end);

  // compare outcome comes from loaded registers
  a_good_known : assert property (@(posedge clk) test_step |-> !$isunknown(test_good));
  a_end_once : assert property (@(posedge clk) test_ended |=> !test_ended until rst);
  // ROM layout must put the end entry right after the last step
  a_end_at_last : assert property (@(posedge clk) test_ended |-> pc == `ECO32_STEPS);

endmodule

// ==== hw/test_rom.sv ====
// --------------------------------------------------------------------------
// test program ROM: one ALU check per entry with its expected result,
// closed by an end entry
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "eco32_defs.svh"

module test_rom
  import cpu_types_pkg::*;
(
  input  logic [`ECO32_AW-1:0] addr,
  output test_op_t             op,
  output logic [`ECO32_DW-1:0] opa,
  output logic [`ECO32_DW-1:0] opb,
  output logic [`ECO32_DW-1:0] expected
);

  always_comb begin
    op       = op_end;
    opa      = '0;
    opb      = '0;
    expected = '0;
    case (addr)
      4'd0: begin
        op = op_add;
        {opa, opb, expected} = {32'h1234_5678, 32'h1111_1111, 32'h2345_6789};
      end
      4'd1: begin
        op = op_sub;
        {opa, opb, expected} = {32'h0000_0010, 32'h0000_0011, 32'hffff_ffff};
      end
      4'd2: begin
        op = op_and;
        {opa, opb, expected} = {32'hf0f0_f0f0, 32'h3c3c_3c3c, 32'h3030_3030};
      end
      4'd3: begin
        op = op_or;
        {opa, opb, expected} = {32'h0f00_0f00, 32'h00f0_00f0, 32'h0ff0_0ff0};
      end
      4'd4: begin
        op = op_xor;
        {opa, opb, expected} = {32'haaaa_5555, 32'hffff_0000, 32'h5555_5555};
      end
      4'd5: begin
        op = op_shl;
        {opa, opb, expected} = {32'h0000_0001, 32'h0000_001f, 32'h8000_0000};
      end
      4'd6: begin
        op = op_shr;
        {opa, opb, expected} = {32'h8000_0000, 32'h0000_0004, 32'h0800_0000};
      end
      // carry out of the msb is dropped
      4'd7: begin
        op = op_add;
        {opa, opb, expected} = {32'hffff_ffff, 32'h0000_0001, 32'h0000_0000};
      end
      default: begin
        op = op_end;   // entry 8 and anything past it
      end
    endcase
  end

endmodule

// ==== hw/reset_gen.sv ====
// --------------------------------------------------------------------------
// reset generator: synchronizes the board reset and stretches the
// release by a fixed number of clock cycles
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "eco32_defs.svh"

module reset_gen (
  input  logic clk,
  input  logic rst,
  output logic sys_rst
);

  localparam int cnt_w = $clog2(`ECO32_RST_HOLD + 1);

  logic             rst_meta;   // first sync stage
  logic             rst_sync;   // second sync stage
  logic [cnt_w-1:0] hold_cnt;

  always_ff @(posedge clk) begin
    rst_meta <= rst;
    rst_sync <= rst_meta;
  end

  // reloaded while reset is seen, counts down after release
  always_ff @(posedge clk) begin
    if (rst_meta) begin
      hold_cnt <= cnt_w'(`ECO32_RST_HOLD);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  assign sys_rst = rst_meta | rst_sync | (hold_cnt != '0);

  // release is stretched by exactly the hold count
  a_hold_length : assert property (@(posedge clk) disable iff (rst_meta)
    $fell(rst_meta) |-> sys_rst [*`ECO32_RST_HOLD] ##1 !sys_rst);

endmodule

// ==== hw/board_types_pkg.sv ====
// --------------------------------------------------------------------------
// board-side types: test verdict and seven-segment pattern
// --------------------------------------------------------------------------
package board_types_pkg;

  typedef enum logic [1:0] {
    v_running = 2'd0,
    v_passed  = 2'd1,
    v_failed  = 2'd2
  } verdict_t;

  // active low, segment 6 in the msb
  typedef logic [6:0] seg7_t;

endpackage

// ==== hw/cpu_types_pkg.sv ====
// --------------------------------------------------------------------------
// self-test CPU types: control phases and test ROM opcodes
// --------------------------------------------------------------------------
package cpu_types_pkg;

  // one step is fetch, execute, report; halt after the end entry
  typedef enum logic [1:0] {
    st_fetch  = 2'd0,
    st_exec   = 2'd1,
    st_report = 2'd2,
    st_halt   = 2'd3
  } cpu_state_t;

  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4,
    op_shl = 3'd5,   // shift count from opb[4:0]
    op_shr = 3'd6,   // logical
    op_end = 3'd7    // end of test program
  } test_op_t;

endpackage

// ==== include/eco32_defs.svh ====
// --------------------------------------------------------------------------
// ECO32 board self-test: global sizes and timing constants
// --------------------------------------------------------------------------
`ifndef ECO32_DEFS_SVH
`define ECO32_DEFS_SVH

`define ECO32_STEPS     8   // ALU checks in the test ROM
`define ECO32_RST_HOLD  4   // sys_rst hold cycles after board reset release
`define ECO32_HB_BITS   26  // heartbeat counter width
`define ECO32_DW        32  // datapath width

// ROM index width, room for all steps plus the end entry
`define ECO32_AW        4

`endif
